/* codewordCorrector.sv */
/*
 * Third stage. Applies the correction vector and registers the result.
 * The data half of result.word is the recovered payload, the CRC half
 * is repaired as well.
 */

`timescale 1ns/1ps
`default_nettype none

module codewordCorrector (
        input  logic           clk,
        input  logic           rstN,
        input  crcPkg::fixT    fix,
        output logic           outValid,
        output crcPkg::resultT result
);
        import crcPkg::*;

        codewordT fixedWord;
        logic     vecZero;

        assign fixedWord = fix.word ^ fix.corrVec;
        assign vecZero   = (fix.corrVec == '0);

        //////////////////////////////////////////////////
        // Output register
        //////////////////////////////////////////////////

        always_ff @(posedge clk) begin
                result.word     <= fixedWord;
                result.errClass <= fix.errClass;
                if (!rstN) begin
                        outValid <= 1'b0;
                end else begin
                        outValid <= fix.valid;
                end
        end

        // Clean and uncorrectable words must leave untouched, corrected ones must not
        classMatchesVector: assert property (
                @(posedge clk) disable iff (!rstN)
                outValid |-> ((result.errClass inside {ErrNone, ErrUncorrectable})
                              == $past(vecZero))
        ) else $error("codewordCorrector: class %s disagrees with the applied vector",
                      result.errClass.name());

endmodule

`default_nettype wire

/* crcCorrectTb.sv */
/*
 * Testbench for the CRC-16 corrector with a table of words applied in a loop.
 * Expected results come from a local decoder model built on DefaultPoly.
 * A double error that shares its syndrome with a lower pair is expected to be
 * repaired toward that lower pair, as the error locator picks the first match.
 */

`timescale 1ns/1ps
`default_nettype none

module crcCorrectTb;
        import crcPkg::*;

        localparam int MaxWait = 20;   // Cycles allowed for the pipeline to drain

        logic     clk;
        logic     rstN;
        logic     inValid;
        codewordT inWord;
        logic     outValid;
        resultT   result;

        int unsigned edgeCount = 0;
        int unsigned seedValue;

        // Stimulus table
        string                tabName   [$];
        logic [DataWidth-1:0] tabData   [$];
        bit                   tabRandom [$];
        codewordT             tabMask   [$];
        int                   tabGap    [$];

        // Words in flight, oldest first
        string       expName  [$];
        codewordT    expWord  [$];
        errClassE    expClass [$];
        int unsigned expEdge  [$];

        syndromeT bitSyn [CwWidth];

        crcCorrectTop #(
                .CrcPoly (DefaultPoly)
        ) dut (
                .clk      (clk),
                .rstN     (rstN),
                .inValid  (inValid),
                .inWord   (inWord),
                .outValid (outValid),
                .result   (result)
        );

        initial begin
                clk = 1'b0;
                forever #5 clk = ~clk;
        end

        always @(posedge clk) edgeCount <= edgeCount + 1;

        //////////////////////////////////////////////////
        // Reference model
        //////////////////////////////////////////////////

        // Remainder of the word polynomial, bits taken MSB first
        function automatic syndromeT remainderOf(input codewordT w);
                syndromeT rem;
                logic     top;
                rem = '0;
                for (int k = CwWidth - 1; k >= 0; k--) begin
                        top = rem[CrcWidth-1];
                        rem = {rem[CrcWidth-2:0], w[k]};
                        if (top) begin
                                rem = rem ^ DefaultPoly;   // Subtract x^16 + poly
                        end
                end
                return rem;
        endfunction

        function automatic codewordT encode(input logic [DataWidth-1:0] data);
                return {data, remainderOf({data, {CrcWidth{1'b0}}})};
        endfunction

        // Zero syndrome, then singles, then pairs in ascending order
        task automatic decodeModel(input codewordT rx, output codewordT word,
                                   output errClassE cls);
                syndromeT syn;
                bit       done;
                syn  = remainderOf(rx);
                word = rx;
                cls  = ErrUncorrectable;
                done = 1'b0;
                if (syn == '0) begin
                        cls  = ErrNone;
                        done = 1'b1;
                end
                for (int i = 0; i < CwWidth; i++) begin
                        if (!done && bitSyn[i] == syn) begin
                                word = rx ^ (codewordT'(1) << i);
                                cls  = ErrSingle;
                                done = 1'b1;
                        end
                end
                for (int a = 0; a < CwWidth - 1; a++) begin
                        for (int b = a + 1; b < CwWidth; b++) begin
                                if (!done && (bitSyn[a] ^ bitSyn[b]) == syn) begin
                                        word = rx ^ (codewordT'(1) << a) ^ (codewordT'(1) << b);
                                        cls  = ErrDouble;
                                        done = 1'b1;
                                end
                        end
                end
        endtask

        //////////////////////////////////////////////////
        // Stimulus table
        //////////////////////////////////////////////////

        task automatic addEntry(input string name, input logic [DataWidth-1:0] data,
                                input bit isRandom, input codewordT mask, input int gap);
                tabName.push_back(name);
                tabData.push_back(data);
                tabRandom.push_back(isRandom);
                tabMask.push_back(mask);
                tabGap.push_back(gap);   // Idle cycles after this word
        endtask

        function automatic codewordT pairMask(input int unsigned a, input int unsigned b);
                return (codewordT'(1) << a) | (codewordT'(1) << b);
        endfunction

        task automatic buildTable();
                int unsigned a;
                int unsigned b;
                addEntry("clean_zero", 16'h0000, 1'b0, '0, 0);
                addEntry("clean_ffff", 16'hFFFF, 1'b0, '0, 2);
                addEntry("clean_a5c3", 16'hA5C3, 1'b0, '0, 0);
                addEntry("clean_random", 16'h0000, 1'b1, '0, 3);
                for (int i = 0; i < CwWidth; i++) begin
                        addEntry($sformatf("single_%0d", i), 16'h0000, 1'b1,
                                 codewordT'(1) << i, (i == 15) ? 4 : 0);
                end
                addEntry("double_adj_0_1", 16'h1234, 1'b0, pairMask(0, 1), 0);
                addEntry("double_adj_15_16", 16'hBEEF, 1'b0, pairMask(15, 16), 0);
                addEntry("double_adj_30_31", 16'h0F0F, 1'b0, pairMask(30, 31), 1);
                addEntry("double_ends_0_31", 16'h8001, 1'b0, pairMask(0, 31), 0);
                addEntry("double_data_crc_4_27", 16'h5A5A, 1'b0, pairMask(4, 27), 0);
                addEntry("double_0_5", 16'hC3C3, 1'b0, pairMask(0, 5), 0);
                addEntry("double_12_16", 16'hC3C3, 1'b0, pairMask(12, 16), 2);
                for (int n = 0; n < 16; n++) begin
                        a = $urandom % CwWidth;
                        b = (a + 1 + $urandom % (CwWidth - 1)) % CwWidth;
                        addEntry($sformatf("double_random_%0d_%0d", a, b), 16'h0000, 1'b1,
                                 pairMask(a, b), int'($urandom % 3));
                end
        endtask

        //////////////////////////////////////////////////
        // Checks
        //////////////////////////////////////////////////

        task automatic stopOnError(input string what);
                $display("%s", what);
                $display("** FAIL **");
                $fatal(1, "Simulation stopped at the first error");
        endtask

        // Outputs are stable at the falling edge
        always @(negedge clk) begin : checkOutput
                string       name;
                codewordT    word;
                errClassE    cls;
                int unsigned due;
                if (outValid) begin
                        assert (expWord.size() > 0) else
                                stopOnError($sformatf("Output valid at edge %0d with no word in flight",
                                                      edgeCount));
                        name = expName.pop_front();
                        word = expWord.pop_front();
                        cls  = expClass.pop_front();
                        due  = expEdge.pop_front();
                        assert (edgeCount == due) else
                                stopOnError($sformatf("error: test %s expected edge %0d, actual %0d",
                                                      name, due, edgeCount));
                        assert (result.word == word) else
                                stopOnError($sformatf("error: test %s expected word %h, actual %h",
                                                      name, word, result.word));
                        assert (result.errClass == cls) else
                                stopOnError($sformatf("error: test %s expected class %s, actual %s",
                                                      name, cls.name(), result.errClass.name()));
                end
        end

        //////////////////////////////////////////////////
        // Main sequence
        //////////////////////////////////////////////////

        initial begin
                logic [DataWidth-1:0] data;
                codewordT             rx;
                codewordT             word;
                errClassE             cls;
                int                   waited;
                rstN    <= 1'b0;
                inValid <= 1'b0;
                inWord  <= '0;
                seedValue = $urandom(56);
                for (int i = 0; i < CwWidth; i++) begin
                        bitSyn[i] = remainderOf(codewordT'(1) << i);
                end
                buildTable();

                repeat (5) @(posedge clk);
                rstN <= 1'b1;

                for (int n = 0; n < tabName.size(); n++) begin
                        @(posedge clk);
                        if (tabRandom[n]) begin
                                data = DataWidth'($urandom);
                        end else begin
                                data = tabData[n];
                        end
                        rx = encode(data) ^ tabMask[n];
                        decodeModel(rx, word, cls);
                        expName.push_back(tabName[n]);
                        expWord.push_back(word);
                        expClass.push_back(cls);
                        // The edge counter updates nonblocking and still lags by one here
                        expEdge.push_back(edgeCount + 4);   // Sampled next edge, out 3 edges later
                        inValid <= 1'b1;
                        inWord  <= rx;
                        for (int g = 0; g < tabGap[n]; g++) begin
                                @(posedge clk);
                                inValid <= 1'b0;
                        end
                end
                @(posedge clk);
                inValid <= 1'b0;

                waited = 0;
                while (expWord.size() > 0 && waited < MaxWait) begin
                        @(posedge clk);
                        waited++;
                end
                if (expWord.size() == 0) begin
                        repeat (6) @(posedge clk);   // Stray outputs would show up here
                        $display("** PASS **");
                        $finish;
                end else begin
                        stopOnError($sformatf("Output for test %s never came within %0d cycles",
                                              expName[0], MaxWait));
                end
        end

endmodule

`default_nettype wire

/* crcCorrectTop.sv */
/*
 * CRC-16 corrector for 32-bit codewords, three register stages.
 * A word sampled with inValid comes out with outValid exactly 3 cycles later.
 * There is no back-pressure, so a word may enter every cycle.
 */

`timescale 1ns/1ps
`default_nettype none

module crcCorrectTop #(
        parameter crcPkg::syndromeT CrcPoly = crcPkg::DefaultPoly
) (
        input  logic             clk,
        input  logic             rstN,
        input  logic             inValid,
        input  crcPkg::codewordT inWord,
        output logic             outValid,
        output crcPkg::resultT   result
);
        import crcPkg::*;

        stageT stage;   // Syndrome stage to locator
        fixT   fix;     // Locator to corrector

        //////////////////////////////////////////////////
        // Pipeline
        //////////////////////////////////////////////////

        syndromeCalc #(
                .CrcPoly (CrcPoly)
        ) uSyndromeCalc (
                .clk     (clk),
                .rstN    (rstN),
                .inValid (inValid),
                .inWord  (inWord),
                .stage   (stage)
        );

        errorLocator #(
                .CrcPoly (CrcPoly)
        ) uErrorLocator (
                .clk   (clk),
                .rstN  (rstN),
                .stage (stage),
                .fix   (fix)
        );

        codewordCorrector uCodewordCorrector (
                .clk      (clk),
                .rstN     (rstN),
                .fix      (fix),
                .outValid (outValid),
                .result   (result)
        );

endmodule

`default_nettype wire

/* crcPkg.sv */
/*
 * Shared widths, types and the bit syndrome function for the CRC-16 corrector.
 * Polynomials are given without the x^16 term, so 0x1021 means x^16+x^12+x^5+1.
 * Codeword layout puts the data in the upper half and the CRC in the lower half.
 */

`default_nettype none

package crcPkg;

        localparam int CwWidth   = 32;
        localparam int CrcWidth  = 16;
        localparam int DataWidth = CwWidth - CrcWidth;

        localparam logic [CrcWidth-1:0] DefaultPoly = 16'h1021;   // CRC-16/CCITT generator

        typedef logic [CwWidth-1:0]  codewordT;
        typedef logic [CrcWidth-1:0] syndromeT;

        typedef enum logic [1:0] {
                ErrNone,
                ErrSingle,
                ErrDouble,
                ErrUncorrectable
        } errClassE;

        //////////////////////////////////////////////////
        // Pipeline payloads
        //////////////////////////////////////////////////

        typedef struct packed {
                logic     valid;
                codewordT word;
                syndromeT syndrome;
        } stageT;

        typedef struct packed {
                logic     valid;
                codewordT word;
                codewordT corrVec;     // XOR mask that repairs word
                errClassE errClass;
        } fixT;

        typedef struct packed {
                codewordT word;
                errClassE errClass;
        } resultT;

        // Remainder of x^pos divided by the generator
        // A flipped bit at position pos shifts the syndrome by exactly this value
        function automatic syndromeT bitSyndrome(input int unsigned pos, input syndromeT poly);
                syndromeT rem;
                logic     msb;
                rem = syndromeT'(1);
                for (int unsigned k = 0; k < pos; k++) begin
                        msb = rem[CrcWidth-1];
                        rem = rem << 1;
                        if (msb) begin
                                rem = rem ^ poly;   // Reduce once x^16 appears
                        end
                end
                return rem;
        endfunction

endpackage

`default_nettype wire

/* errorLocator.sv */
/*
 * Second stage. Matches the syndrome against all 32 single and 496 pair patterns.
 * The default generator has weight 4, so a few pairs share a syndrome, such as
 * bits {0,5} and {12,16}. The lowest pair wins and the other one is miscorrected.
 * Syndromes with no match pass the word through as uncorrectable.
 */

`timescale 1ns/1ps
`default_nettype none

module errorLocator #(
        parameter crcPkg::syndromeT CrcPoly = crcPkg::DefaultPoly
) (
        input  logic          clk,
        input  logic          rstN,
        input  crcPkg::stageT stage,
        output crcPkg::fixT   fix
);
        import crcPkg::*;

        localparam int NumPairs = CwWidth * (CwWidth - 1) / 2;

        syndromeT            bitSyn [CwWidth];
        logic [CwWidth-1:0]  singleHit;     // Already one-hot when it is the answer
        logic [NumPairs-1:0] pairHit;
        codewordT            pairVec;
        codewordT            nextVec;
        errClassE            nextClass;
        syndromeT            fixSyn;

        // Flat index of the pair (a, b) with a < b
        function automatic int pairIndex(input int a, input int b);
                return a * (2 * CwWidth - a - 1) / 2 + (b - a - 1);
        endfunction

        //////////////////////////////////////////////////
        // Pattern compare
        //////////////////////////////////////////////////

        for (genvar i = 0; i < CwWidth; i++) begin : gSingle
                assign bitSyn[i]    = bitSyndrome(i, CrcPoly);
                assign singleHit[i] = (stage.syndrome == bitSyn[i]);
        end

        for (genvar a = 0; a < CwWidth - 1; a++) begin : gPairA
                for (genvar b = a + 1; b < CwWidth; b++) begin : gPairB
                        assign pairHit[pairIndex(a, b)] =
                                (stage.syndrome == (bitSyn[a] ^ bitSyn[b]));
                end
        end

        // Two-hot vector of the first matching pair
        always_comb begin
                logic found;
                found   = 1'b0;
                pairVec = '0;
                for (int a = 0; a < CwWidth - 1; a++) begin
                        for (int b = a + 1; b < CwWidth; b++) begin
                                if (!found && pairHit[pairIndex(a, b)]) begin
                                        found      = 1'b1;
                                        pairVec[a] = 1'b1;
                                        pairVec[b] = 1'b1;
                                end
                        end
                end
        end

        //////////////////////////////////////////////////
        // Classification
        //////////////////////////////////////////////////

        always_comb begin
                if (stage.syndrome == '0) begin
                        nextClass = ErrNone;
                        nextVec   = '0;
                end else if (|singleHit) begin
                        nextClass = ErrSingle;
                        nextVec   = singleHit;
                end else if (|pairHit) begin
                        nextClass = ErrDouble;
                        nextVec   = pairVec;
                end else begin
                        nextClass = ErrUncorrectable;   // Three or more flips, word left alone
                        nextVec   = '0;
                end
        end

        always_ff @(posedge clk) begin
                fix.word     <= stage.word;
                fix.corrVec  <= nextVec;
                fix.errClass <= nextClass;
                if (!rstN) begin
                        fix.valid <= 1'b0;
                end else begin
                        fix.valid <= stage.valid;
                end
        end

        //////////////////////////////////////////////////
        // Checks
        //////////////////////////////////////////////////

        // Syndrome of the registered vector, rebuilt from the bit table
        always_comb begin
                fixSyn = '0;
                for (int i = 0; i < CwWidth; i++) begin
                        if (fix.corrVec[i]) begin
                                fixSyn = fixSyn ^ bitSyn[i];
                        end
                end
        end

        // All single syndromes differ, and no single equals a pair since every
        // codeword of this generator has even weight
        singleUnique: assert property (
                @(posedge clk) disable iff (!rstN)
                stage.valid |-> $onehot0(singleHit) && !(|singleHit && |pairHit)
        ) else $error("errorLocator: syndrome %h matched more than one pattern class",
                      stage.syndrome);

        // A correction must cancel exactly the syndrome it was chosen for
        vectorCancelsSyndrome: assert property (
                @(posedge clk) disable iff (!rstN)
                fix.valid && (fix.errClass inside {ErrSingle, ErrDouble})
                        |-> fixSyn == $past(stage.syndrome)
        ) else $error("errorLocator: vector %h does not cancel syndrome %h",
                      fix.corrVec, $past(stage.syndrome));

endmodule

`default_nettype wire

/* files.f */
crcPkg.sv
syndromeCalc.sv
errorLocator.sv
codewordCorrector.sv
crcCorrectTop.sv
crcCorrectTb.sv

/* run.sh */
#!/bin/sh
# Build the corrector and its testbench with Verilator, then run the simulation
# A nonzero exit status means the run did not pass
cd "$(dirname "$0")" &&
verilator --binary --timing --assert --top-module crcCorrectTb -f files.f -o crcCorrectSim &&
./obj_dir/crcCorrectSim ||
{ echo "Simulation did not pass"; exit 1; }

/* syndromeCalc.sv */
/*
 * First stage. The CRC is MSB first, zero initial value, no reflection and
 * no final XOR. A zero syndrome means the received word is a valid codeword.
 */

`timescale 1ns/1ps
`default_nettype none

module syndromeCalc #(
        parameter crcPkg::syndromeT CrcPoly = crcPkg::DefaultPoly
) (
        input  logic             clk,
        input  logic             rstN,
        input  logic             inValid,
        input  crcPkg::codewordT inWord,
        output crcPkg::stageT    stage
);
        import crcPkg::*;

        syndromeT dataRem;
        syndromeT syndrome;

        //////////////////////////////////////////////////
        // Long division of the data half
        //////////////////////////////////////////////////

        // Remainder of data times x^16, shifted in one bit at a time
        always_comb begin
                dataRem = '0;
                for (int k = DataWidth - 1; k >= 0; k--) begin
                        if (dataRem[CrcWidth-1] ^ inWord[CrcWidth + k]) begin
                                dataRem = (dataRem << 1) ^ CrcPoly;
                        end else begin
                                dataRem = dataRem << 1;
                        end
                end
        end

        // The received CRC has degree below 16, so it folds in unreduced
        assign syndrome = dataRem ^ inWord[CrcWidth-1:0];

        //////////////////////////////////////////////////
        // Stage register
        //////////////////////////////////////////////////

        always_ff @(posedge clk) begin
                stage.word     <= inWord;
                stage.syndrome <= syndrome;
                if (!rstN) begin
                        stage.valid <= 1'b0;
                end else begin
                        stage.valid <= inValid;
                end
        end

        // Nothing may leave the first stage right after a reset cycle
        validClearedAfterReset: assert property (
                @(posedge clk) !rstN |=> !stage.valid
        ) else $error("syndromeCalc: stage valid set in the cycle after reset");

endmodule

`default_nettype wire
